// ==== include/cyclecnt_params.svh ====
// ======================================================================
// Width and limit macros for the instruction timer, the mcycle
// accumulator and the fetch sequencer
// ======================================================================
`ifndef CYCLECNT_PARAMS_SVH
`define CYCLECNT_PARAMS_SVH

// Data and address width of the core
`define CC_XLEN 32

// Instruction timer width
// Overflow at 64 ends start-up and flags a runaway instruction
`define CC_CNT_WIDTH 6

// Machine cycle counter width
`define CC_TIME_WIDTH 64

// Execute-cycle count of a single instruction
`define CC_EXEC_WIDTH 6

`endif

// ==== hw/opsel_pkg.sv ====
// ======================================================================
// Operand-B select type shared by the sequencer and the timer mux
// ======================================================================
`default_nettype none

package opsel_pkg;

    // Operand-B source, encoded after the microcode select pair
    //   OPB_INCR   {addr[5:2], 2'b11} so carry-in gives PC + 4
    //   OPB_TIMER  instruction timer in the low bits
    //   OPB_ADDR   address passes through
    //   OPB_IDLE   between instructions, address passes through
    typedef enum logic [1:0] {
        OPB_INCR  = 2'b00,
        OPB_TIMER = 2'b01,
        OPB_ADDR  = 2'b10,
        OPB_IDLE  = 2'b11
    } opsel_t;

endpackage

`default_nettype wire

// ==== hw/core_status_pkg.sv ====
// ======================================================================
// Run-state and trap-cause types of the core
// ======================================================================
`default_nettype none

package core_status_pkg;

    // Core run state, sticky once trapped
    typedef enum logic [1:0] {
        RS_HELD    = 2'd0,
        RS_RUNNING = 2'd1,
        RS_TRAPPED = 2'd2
    } run_state_t;

    // Reason for the last trap
    typedef enum logic [1:0] {
        TRAP_NONE      = 2'd0,
        TRAP_BUS_ERROR = 2'd1
    } trap_cause_t;

endpackage

`default_nettype wire

// ==== hw/instr_cycle_timer.sv ====
// ======================================================================
// Instruction timer with carry out, operand-B low-bit mux,
// start-up gate and bus-error detection
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "cyclecnt_params.svh"

module instr_cycle_timer import opsel_pkg::*; (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic                      start,
    input  wire logic [`CC_XLEN-1:0]       pc_addr,
    input  wire opsel_t                    opb_sel,
    output logic      [`CC_XLEN-1:0]       operand_b,
    output logic      [`CC_CNT_WIDTH-1:0]  timer_sample,
    output logic                           core_running,
    output logic                           bus_error
);

    localparam int CW = `CC_CNT_WIDTH;

    // Registered count and its next value
    // Top bit of the next value is the carry out of the counter
    logic [CW-1:0] rccnt;
    logic [CW:0]   ccnt;
    logic          cnt_carry;

    // Low bits of operand B after the select mux
    logic [CW-1:0] opb_low;

    // Start-up gate register
    logic          rcrun;

    // ==================================================================
    // Timer next value
    // ==================================================================

    // Start low holds the timer at 1
    // A sample cycle restarts the count at 1 for the next instruction
    always_comb begin
        if (!start) begin
            ccnt = (CW + 1)'(1);
        end else if (opb_sel == OPB_TIMER) begin
            ccnt = (CW + 1)'(1);
        end else begin
            ccnt = {1'b0, rccnt} + (CW + 1)'(1);
        end
    end

    assign cnt_carry = ccnt[CW];

    // Counter drops the carry, so it wraps to zero on overflow
    always_ff @(posedge clk) begin
        if (reset) begin
            rccnt <= CW'(1);
        end else begin
            rccnt <= ccnt[CW-1:0];
        end
    end

    assign timer_sample = rccnt;

    // ==================================================================
    // Start-up gate
    // ==================================================================

    // Needs 64 start cycles in a row before the first carry
    // Once set, only reset clears it
    always_ff @(posedge clk) begin
        if (reset) begin
            rcrun <= 1'b0;
        end else begin
            rcrun <= rcrun | (cnt_carry & start);
        end
    end

    assign core_running = rcrun;

    // ==================================================================
    // Bus-error detect
    // ==================================================================

    // Instruction ran 64 cycles without a sample, surely a hung bus
    // The wrap to zero makes this a single-cycle pulse
    assign bus_error = rcrun & cnt_carry & (opb_sel != OPB_TIMER);

    // ==================================================================
    // Operand-B mux
    // ==================================================================

    always_comb begin
        unique case (opb_sel)
            OPB_TIMER: opb_low = rccnt;
            // Low two bits forced high, ALU carry-in completes PC + 4
            OPB_INCR:  opb_low = {pc_addr[CW-1:2], 2'b11};
            OPB_ADDR,
            OPB_IDLE:  opb_low = pc_addr[CW-1:0];
            default:   opb_low = pc_addr[CW-1:0];
        endcase
    end

    // Upper address bits always pass through
    assign operand_b = {pc_addr[`CC_XLEN-1:CW], opb_low};

    // ==================================================================
    // Assertions
    // ==================================================================

    // No trap can be raised while the core is still held
    a_no_bus_error_when_held: assert property (
        @(posedge clk) disable iff (reset)
        bus_error |-> core_running
    );

endmodule

`default_nettype wire

// ==== hw/cycle_time_accum.sv ====
// ======================================================================
// 64-bit mcycle register, adds the instruction timer sample
// one cycle after each sample cycle
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "cyclecnt_params.svh"

module cycle_time_accum import opsel_pkg::*; (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire opsel_t                    opb_sel,
    input  wire logic [`CC_CNT_WIDTH-1:0]  timer_sample,
    output logic      [`CC_TIME_WIDTH-1:0] mcycle
);

    localparam int CW = `CC_CNT_WIDTH;
    localparam int TW = `CC_TIME_WIDTH;

    // Sample strobe, formed here from the select
    logic          sample_now;

    // Delayed strobe and the captured timer value
    logic          sample_q;
    logic [CW-1:0] sample_val;

    assign sample_now = (opb_sel == OPB_TIMER);

    // ==================================================================
    // Sample capture
    // ==================================================================

    // Timer reloads right after the sample cycle, so hold its value
    always_ff @(posedge clk) begin
        if (reset) begin
            sample_q <= 1'b0;
        end else begin
            sample_q <= sample_now;
        end
    end

    always_ff @(posedge clk) begin
        if (sample_now) begin
            sample_val <= timer_sample;
        end
    end

    // ==================================================================
    // Accumulate
    // ==================================================================

    // Zero-extended sample added the cycle after capture
    always_ff @(posedge clk) begin
        if (reset) begin
            mcycle <= '0;
        end else if (sample_q) begin
            mcycle <= mcycle + {{(TW - CW){1'b0}}, sample_val};
        end
    end

    // Cycle count only ever grows outside reset
    a_mcycle_monotonic: assert property (
        @(posedge clk) disable iff (reset)
        !$past(reset) |-> (mcycle >= $past(mcycle))
    );

endmodule

`default_nettype wire

// ==== hw/fetch_sequencer.sv ====
// ======================================================================
// Per-instruction phase machine standing in for the microcode
// Drives the operand-B select, instr_done and run state
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "cyclecnt_params.svh"

module fetch_sequencer
    import opsel_pkg::*;
    import core_status_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       core_running,
    input  wire logic                       bus_error,
    input  wire logic                       instr_valid,
    input  wire logic [`CC_EXEC_WIDTH-1:0]  instr_exec_cycles,
    output opsel_t                          opb_sel,
    output logic                            instr_done,
    output run_state_t                      run_state,
    output trap_cause_t                     trap_cause
);

    localparam int EW = `CC_EXEC_WIDTH;

    // Instruction phases
    typedef enum logic [1:0] {
        PH_IDLE   = 2'd0,
        PH_SAMPLE = 2'd1,
        PH_INCR   = 2'd2,
        PH_EXEC   = 2'd3
    } phase_t;

    phase_t        phase;

    // Execute cycles still to run
    logic [EW-1:0] exec_left;

    // ==================================================================
    // Phase machine
    // ==================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            phase      <= PH_IDLE;
            exec_left  <= '0;
            instr_done <= 1'b0;
            run_state  <= RS_HELD;
            trap_cause <= TRAP_NONE;
        end else begin
            // Done is a single-cycle pulse
            instr_done <= 1'b0;

            if (bus_error && run_state != RS_TRAPPED) begin
                // Drop the instruction, no done pulse
                phase      <= PH_IDLE;
                run_state  <= RS_TRAPPED;
                trap_cause <= TRAP_BUS_ERROR;
            end else begin
                // Leave hold once the timer has released the core
                if (run_state == RS_HELD && core_running) begin
                    run_state <= RS_RUNNING;
                end

                unique case (phase)
                    PH_IDLE: begin
                        // Strobes while held, trapped or busy are lost
                        if (instr_valid && run_state == RS_RUNNING) begin
                            phase     <= PH_SAMPLE;
                            exec_left <= instr_exec_cycles;
                        end
                    end
                    PH_SAMPLE: begin
                        phase <= PH_INCR;
                    end
                    PH_INCR: begin
                        // Zero execute cycles finishes right after the step
                        if (exec_left == '0) begin
                            phase      <= PH_IDLE;
                            instr_done <= 1'b1;
                        end else begin
                            phase <= PH_EXEC;
                        end
                    end
                    PH_EXEC: begin
                        if (exec_left == EW'(1)) begin
                            phase      <= PH_IDLE;
                            instr_done <= 1'b1;
                        end else begin
                            exec_left <= exec_left - EW'(1);
                        end
                    end
                    default: begin
                        phase <= PH_IDLE;
                    end
                endcase
            end
        end
    end

    // ==================================================================
    // Operand-B select
    // ==================================================================

    // Decoded from the phase register, so glitch-free per cycle
    always_comb begin
        unique case (phase)
            PH_SAMPLE: opb_sel = OPB_TIMER;
            PH_INCR:   opb_sel = OPB_INCR;
            PH_EXEC:   opb_sel = OPB_ADDR;
            default:   opb_sel = OPB_IDLE;
        endcase
    end

    // Completion and the timer sample never share a cycle
    a_done_not_in_sample: assert property (
        @(posedge clk) disable iff (reset)
        instr_done |-> (opb_sel != OPB_TIMER)
    );

endmodule

`default_nettype wire

// ==== hw/core_timing_top.sv ====
// ======================================================================
// Timing top level with instruction timer, mcycle accumulator
// and fetch sequencer
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "cyclecnt_params.svh"

module core_timing_top
    import opsel_pkg::*;
    import core_status_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       start,
    input  wire logic [`CC_XLEN-1:0]        pc_addr,
    input  wire logic                       instr_valid,
    input  wire logic [`CC_EXEC_WIDTH-1:0]  instr_exec_cycles,
    output logic      [`CC_XLEN-1:0]        operand_b,
    output opsel_t                          opb_sel,
    output logic                            core_running,
    output run_state_t                      run_state,
    output trap_cause_t                     trap_cause,
    output logic      [`CC_TIME_WIDTH-1:0]  mcycle,
    output logic                            instr_done
);

    // Timer to accumulator and sequencer
    logic [`CC_CNT_WIDTH-1:0] timer_sample;
    logic                     bus_error;

    instr_cycle_timer i_instr_cycle_timer (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .pc_addr      (pc_addr),
        .opb_sel      (opb_sel),
        .operand_b    (operand_b),
        .timer_sample (timer_sample),
        .core_running (core_running),
        .bus_error    (bus_error)
    );

    cycle_time_accum i_cycle_time_accum (
        .clk          (clk),
        .reset        (reset),
        .opb_sel      (opb_sel),
        .timer_sample (timer_sample),
        .mcycle       (mcycle)
    );

    fetch_sequencer i_fetch_sequencer (
        .clk               (clk),
        .reset             (reset),
        .core_running      (core_running),
        .bus_error         (bus_error),
        .instr_valid       (instr_valid),
        .instr_exec_cycles (instr_exec_cycles),
        .opb_sel           (opb_sel),
        .instr_done        (instr_done),
        .run_state         (run_state),
        .trap_cause        (trap_cause)
    );

endmodule

`default_nettype wire

// ==== test/tb_core_timing.sv ====
// ======================================================================
// Testbench for the core timing top level
// Random instruction stream, cycle model of timer and mcycle,
// per-cycle operand-B checks and the final bus-error trap
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "cyclecnt_params.svh"

module tb_core_timing
    import opsel_pkg::*;
    import core_status_pkg::*;
();

    localparam int XW         = `CC_XLEN;
    localparam int CW         = `CC_CNT_WIDTH;
    localparam int NUM_INSTR  = 40;
    localparam int WAIT_LIMIT = 200;

    // DUT ports
    logic                       clk;
    logic                       reset;
    logic                       start;
    logic [XW-1:0]              pc_addr;
    logic                       instr_valid;
    logic [`CC_EXEC_WIDTH-1:0]  instr_exec_cycles;
    logic [XW-1:0]              operand_b;
    opsel_t                     opb_sel;
    logic                       core_running;
    run_state_t                 run_state;
    trap_cause_t                trap_cause;
    logic [`CC_TIME_WIDTH-1:0]  mcycle;
    logic                       instr_done;

    // Model state
    // cyc counts cycles since core_running rose, last_sample is the
    // cycle of the previous timer sample
    bit                         run_seen;
    int                         cyc;
    int                         last_sample;
    int                         upd_delay;
    logic [`CC_TIME_WIDTH-1:0]  model_mcycle;
    logic [`CC_TIME_WIDTH-1:0]  pend_mcycle;

    core_timing_top i_core_timing_top (
        .clk               (clk),
        .reset             (reset),
        .start             (start),
        .pc_addr           (pc_addr),
        .instr_valid       (instr_valid),
        .instr_exec_cycles (instr_exec_cycles),
        .operand_b         (operand_b),
        .opb_sel           (opb_sel),
        .core_running      (core_running),
        .run_state         (run_state),
        .trap_cause        (trap_cause),
        .mcycle            (mcycle),
        .instr_done        (instr_done)
    );

    // ==================================================================
    // Clock and address stimulus
    // ==================================================================

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // New random PC every cycle
    always @(posedge clk) begin
        pc_addr <= $urandom;
    end

    // ==================================================================
    // Helpers
    // ==================================================================

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
            $display("Checks failed");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
        $display("Checks failed");
        $fatal(1, "Wait timed out");
    endtask

    // One instruction after gap idle cycles, then latency check
    task automatic issue_instruction(input int exec, input int gap);
        int lat;
        repeat (gap) @(posedge clk);
        @(posedge clk);
        instr_valid       <= 1'b1;
        instr_exec_cycles <= 6'(exec);
        @(negedge clk);
        lat = 0;
        while (!instr_done) begin
            if (lat >= WAIT_LIMIT) report_timeout("instr_done");
            @(posedge clk);
            instr_valid       <= 1'b0;
            instr_exec_cycles <= 6'($urandom);
            @(negedge clk);
            lat++;
        end
        // Sample, step, exec cycles, then the done cycle
        check_value("instr_latency", 64'(exec + 3), 64'(lat));
    endtask

    // ==================================================================
    // Per-cycle monitor and model
    // ==================================================================

    // Sampled mid-cycle, where registers and the mux are settled
    always @(negedge clk) begin
        if (!reset) begin
            check_value("opb_upper", 64'(pc_addr[XW-1:CW]), 64'(operand_b[XW-1:CW]));

            // Cycle count starts at 0 in the first running cycle
            if (core_running) begin
                if (!run_seen) begin
                    run_seen    = 1'b1;
                    cyc         = 0;
                    last_sample = 0;
                end else begin
                    cyc++;
                end
            end

            // mcycle picks up a sample two cycles after the sample cycle
            if (upd_delay > 0) begin
                upd_delay--;
                if (upd_delay == 0) begin
                    model_mcycle = pend_mcycle;
                end
            end

            case (opb_sel)
                OPB_INCR: begin
                    check_value("opb_incr", 64'({pc_addr[5:2], 2'b11}),
                                64'(operand_b[CW-1:0]));
                end
                OPB_TIMER: begin
                    check_value("timer_sample", 64'(cyc - last_sample),
                                64'(operand_b[CW-1:0]));
                    last_sample = cyc;
                    pend_mcycle = 64'(cyc);
                    upd_delay   = 2;
                end
                default: begin
                    check_value("opb_addr", 64'(pc_addr[CW-1:0]), 64'(operand_b[CW-1:0]));
                end
            endcase

            check_value("mcycle", model_mcycle, mcycle);

            // Held or trapped core keeps the select idle
            if (!core_running || run_state == RS_TRAPPED) begin
                check_value("opb_sel_idle", 64'(OPB_IDLE), 64'(opb_sel));
            end
            if (run_state == RS_TRAPPED) begin
                check_value("trap_cause_set", 64'(TRAP_BUS_ERROR), 64'(trap_cause));
            end else begin
                check_value("trap_cause_clear", 64'(TRAP_NONE), 64'(trap_cause));
            end
        end
    end

    // ==================================================================
    // Main sequence
    // ==================================================================

    initial begin
        int seed_ret;
        int n_start;
        int since_low;
        int exec;
        int gap;
        int waited;

        seed_ret     = $urandom(32'h371b05d3);
        run_seen     = 1'b0;
        cyc          = 0;
        last_sample  = 0;
        upd_delay    = 0;
        model_mcycle = '0;
        pend_mcycle  = '0;

        reset             = 1'b1;
        start             = 1'b0;
        pc_addr           = '0;
        instr_valid       = 1'b0;
        instr_exec_cycles = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // Start toggles at random, last cycle of this phase is low
        // Strobes while held must be ignored
        n_start = 10 + $urandom_range(0, 20);
        for (int i = 0; i < n_start; i++) begin
            @(posedge clk);
            start       <= (i == n_start - 1) ? 1'b0 : 1'($urandom_range(0, 1));
            instr_valid <= 1'($urandom_range(0, 1));
            @(negedge clk);
            check_value("held_running", 64'd0, 64'(core_running));
        end

        // Start held high, gate opens after 64 cycles
        since_low = 0;
        while (!core_running) begin
            if (since_low >= WAIT_LIMIT) report_timeout("core_running rising");
            @(posedge clk);
            start       <= 1'b1;
            instr_valid <= 1'($urandom_range(0, 1));
            @(negedge clk);
            since_low++;
        end
        check_value("startup_cycles", 64'd64, 64'(since_low));

        @(posedge clk);
        instr_valid <= 1'b0;
        @(negedge clk);
        check_value("run_state_running", 64'(RS_RUNNING), 64'(run_state));

        // Sample interval stays below 64 with exec up to 40 and gap up to 15
        for (int n = 0; n < NUM_INSTR; n++) begin
            exec = $urandom_range(0, 40);
            gap  = $urandom_range(0, 15);
            issue_instruction(exec, gap);
        end

        // ==============================================================
        // Runaway instruction
        // ==============================================================

        // Timer reaches 63 outside a sample once exec plus 2 reaches 64
        exec = 62 + $urandom_range(0, 1);
        gap  = $urandom_range(0, 15);
        repeat (gap) @(posedge clk);
        @(posedge clk);
        instr_valid       <= 1'b1;
        instr_exec_cycles <= 6'(exec);
        @(negedge clk);
        waited = 0;
        while (run_state != RS_TRAPPED) begin
            if (waited >= WAIT_LIMIT) report_timeout("bus-error trap");
            @(posedge clk);
            instr_valid <= 1'b0;
            @(negedge clk);
            waited++;
            check_value("no_done_before_trap", 64'd0, 64'(instr_done));
        end
        // Sample one cycle after the strobe, overflow 63 later, state next
        check_value("trap_cycle", 64'd65, 64'(waited));

        // Trap is sticky and new strobes are dropped
        for (int i = 0; i < 100; i++) begin
            @(posedge clk);
            instr_valid       <= 1'($urandom_range(0, 1));
            instr_exec_cycles <= 6'($urandom);
            @(negedge clk);
            check_value("trapped_state", 64'(RS_TRAPPED), 64'(run_state));
            check_value("trapped_cause", 64'(TRAP_BUS_ERROR), 64'(trap_cause));
            check_value("trapped_no_done", 64'd0, 64'(instr_done));
        end

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
hw/opsel_pkg.sv
hw/core_status_pkg.sv
hw/instr_cycle_timer.sv
hw/cycle_time_accum.sv
hw/fetch_sequencer.sv
hw/core_timing_top.sv
test/tb_core_timing.sv

// ==== Makefile ====
# Verilator build and run for the core timing testbench

TOP := tb_core_timing

.PHONY: all compile run clean

all: run

# Build the simulation binary into obj_dir
compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sim.f

# Pass only when the testbench prints its pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
